/* mmu.f */
+incdir+.
mmu_pkg.sv
tlb_array.sv
mmu_lane.sv
mmu_fault_encoder.sv
mmu.sv
mmu_assert.sv
tb_mmu.sv

/* mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu import mmu_pkg::*; (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [`ASID_W-1:0]              asid,
	input  logic                            user_mode,
	input  logic [`VPN2_W-1:0]              probe_vpn2,
	input  logic                            maint_req,
	input  tlb_cmd_e                        maint_cmd,
	input  logic [`TLB_INDEX_W-1:0]         maint_index,
	input  logic [`TLB_ENTRY_W-1:0]         maint_wdata,
	output logic                            maint_ack,
	output logic [`TLB_ENTRY_W-1:0]         maint_rdata,
	output logic                            probe_hit,
	output logic [`TLB_INDEX_W-1:0]         probe_index,
	input  logic [`MMU_LANES-1:0]           lane_valid,
	input  logic [32*`MMU_LANES-1:0]        vaddr,
	input  access_kind_e [`MMU_LANES-1:0]   kind,
	output logic [`MMU_LANES-1:0]           res_valid,
	output logic [32*`MMU_LANES-1:0]        paddr,
	output logic [`MMU_LANES-1:0]           uncached,
	output exc_code_e [`MMU_LANES-1:0]      exc_code,
	output logic                            any_fault,
	output logic [1:0]                      fault_lane
);

	logic [`TLB_ENTRIES*`TLB_ENTRY_W-1:0] entries;
	logic [`MMU_LANES-1:0]                illegal;
	logic [`MMU_LANES-1:0]                miss;
	logic [`MMU_LANES-1:0]                invalid;
	logic [`MMU_LANES-1:0]                writable;
	access_kind_e [`MMU_LANES-1:0]        res_kind;

	tlb_array i_tlb_array (
		.clk         (clk),
		.arst_n      (arst_n),
		.asid        (asid),
		.maint_req   (maint_req),
		.maint_cmd   (maint_cmd),
		.maint_index (maint_index),
		.maint_wdata (maint_wdata),
		.maint_ack   (maint_ack),
		.maint_rdata (maint_rdata),
		.probe_hit   (probe_hit),
		.probe_index (probe_index),
		.probe_vpn2  (probe_vpn2),
		.entries     (entries)
	);

	// Lane 0 is the fetch port, the rest are data ports
	for (genvar l = 0; l < `MMU_LANES; l++) begin : gen_lane
		mmu_lane i_mmu_lane (
			.clk        (clk),
			.arst_n     (arst_n),
			.asid       (asid),
			.user_mode  (user_mode),
			.entries    (entries),
			.lane_valid (lane_valid[l]),
			.vaddr      (vaddr[32*l +: 32]),
			.kind       (kind[l]),
			.res_valid  (res_valid[l]),
			.paddr      (paddr[32*l +: 32]),
			.uncached   (uncached[l]),
			.illegal    (illegal[l]),
			.miss       (miss[l]),
			.invalid    (invalid[l]),
			.writable   (writable[l]),
			.res_kind   (res_kind[l])
		);
	end

	mmu_fault_encoder i_mmu_fault_encoder (
		.res_valid  (res_valid),
		.illegal    (illegal),
		.miss       (miss),
		.invalid    (invalid),
		.writable   (writable),
		.res_kind   (res_kind),
		.exc_code   (exc_code),
		.any_fault  (any_fault),
		.fault_lane (fault_lane)
	);

endmodule

`default_nettype wire

/* mmu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_assert (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   maint_req,
	input logic                   maint_ack,
	input logic [`MMU_LANES-1:0]  lane_valid,
	input logic [`MMU_LANES-1:0]  res_valid
);

	// Ack may only rise in answer to a request seen on the previous edge
	a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(maint_ack) |-> $past(maint_req))
		else $error("maint_ack rose without a pending maint_req");

	a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(maint_ack) |-> !$past(maint_req))
		else $error("maint_ack fell while maint_req was still high");

	// An idle lane produces no result on the next cycle
	for (genvar l = 0; l < `MMU_LANES; l++) begin : gen_res_idle
		a_res_idle: assert property (@(posedge clk) disable iff (!arst_n)
			!lane_valid[l] |=> !res_valid[l])
			else $error("res_valid set one cycle after an idle lane");
	end

	a_ack_in_reset: assert property (@(posedge clk)
		!arst_n |-> !maint_ack)
		else $error("maint_ack high during reset");

endmodule

bind mmu mmu_assert i_mmu_assert (
	.clk        (clk),
	.arst_n     (arst_n),
	.maint_req  (maint_req),
	.maint_ack  (maint_ack),
	.lane_valid (lane_valid),
	.res_valid  (res_valid)
);

`default_nettype wire

/* mmu_consts.svh */
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// One fetch lane plus two data lanes
`define MMU_LANES      3
`define TLB_ENTRIES    8
`define TLB_INDEX_W    3
`define TLB_ENTRY_W    72

`define VPN2_W         19
`define ASID_W         8
`define PFN_W          20

// Packed entry layout: vpn2, asid, g, {pfn0, v0, d0}, {pfn1, v1, d1}
`define TLB_VPN2_LSB   53
`define TLB_ASID_LSB   45
`define TLB_G_BIT      44
`define TLB_PFN0_LSB   24
`define TLB_V0_BIT     23
`define TLB_D0_BIT     22
`define TLB_PFN1_LSB   2
`define TLB_V1_BIT     1
`define TLB_D1_BIT     0

`endif

/* mmu_fault_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_fault_encoder import mmu_pkg::*; (
	input  logic [`MMU_LANES-1:0]          res_valid,
	input  logic [`MMU_LANES-1:0]          illegal,
	input  logic [`MMU_LANES-1:0]          miss,
	input  logic [`MMU_LANES-1:0]          invalid,
	input  logic [`MMU_LANES-1:0]          writable,
	input  access_kind_e [`MMU_LANES-1:0]  res_kind,
	output exc_code_e [`MMU_LANES-1:0]     exc_code,
	output logic                           any_fault,
	output logic [1:0]                     fault_lane
);

	always_comb begin
		logic is_store;

		for (int l = 0; l < `MMU_LANES; l++) begin
			is_store = (res_kind[l] == ACC_STORE);
			if (!res_valid[l]) begin
				exc_code[l] = EXC_NONE;
			end else if (illegal[l]) begin
				exc_code[l] = is_store ? EXC_ADES : EXC_ADEL;
			end else if (miss[l] || invalid[l]) begin
				// A miss and an invalid page report the same code
				exc_code[l] = is_store ? EXC_TLBS : EXC_TLBL;
			end else if (is_store && !writable[l]) begin
				exc_code[l] = EXC_MOD;
			end else begin
				exc_code[l] = EXC_NONE;
			end
		end
	end

	// Lowest faulting lane, since it is oldest in program order
	always_comb begin
		any_fault  = 1'b0;
		fault_lane = 2'd0;
		for (int l = `MMU_LANES - 1; l >= 0; l--) begin
			if (exc_code[l] != EXC_NONE) begin
				any_fault  = 1'b1;
				fault_lane = 2'(l);
			end
		end
	end

endmodule

`default_nettype wire

/* mmu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_lane import mmu_pkg::*; (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic [`ASID_W-1:0]                      asid,
	input  logic                                    user_mode,
	input  logic [`TLB_ENTRIES*`TLB_ENTRY_W-1:0]    entries,
	input  logic                                    lane_valid,
	input  logic [31:0]                             vaddr,
	input  access_kind_e                            kind,
	output logic                                    res_valid,
	output logic [31:0]                             paddr,
	output logic                                    uncached,
	output logic                                    illegal,
	output logic                                    miss,
	output logic                                    invalid,
	output logic                                    writable,
	output access_kind_e                            res_kind
);

	logic                    mapped;
	logic                    hit;
	logic [`TLB_ENTRY_W-1:0] hit_entry;
	logic [`PFN_W-1:0]       page_pfn;
	logic                    page_v;
	logic                    page_d;

	// useg, kseg2 and kseg3 go through the TLB
	assign mapped = ~vaddr[31] | (vaddr[31:30] == 2'b11);

	always_comb begin
		logic [`TLB_ENTRY_W-1:0] cur;

		hit       = 1'b0;
		hit_entry = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			cur = entries[i*`TLB_ENTRY_W +: `TLB_ENTRY_W];
			if (cur[`TLB_VPN2_LSB +: `VPN2_W] == vaddr[31:13] &&
			    (cur[`TLB_ASID_LSB +: `ASID_W] == asid || cur[`TLB_G_BIT])) begin
				hit       = 1'b1;
				hit_entry = cur;
			end
		end
	end

	// Bit 12 selects the odd half of the dual-page entry
	assign page_pfn = vaddr[12] ? hit_entry[`TLB_PFN1_LSB +: `PFN_W]
	                            : hit_entry[`TLB_PFN0_LSB +: `PFN_W];
	assign page_v   = vaddr[12] ? hit_entry[`TLB_V1_BIT] : hit_entry[`TLB_V0_BIT];
	assign page_d   = vaddr[12] ? hit_entry[`TLB_D1_BIT] : hit_entry[`TLB_D0_BIT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= lane_valid;
		end
	end

	// Results hold their last value while the lane is idle
	always_ff @(posedge clk) begin
		if (lane_valid) begin
			paddr    <= mapped ? {page_pfn, vaddr[11:0]} : {3'b000, vaddr[28:0]};
			uncached <= (vaddr[31:29] == 3'b101);
			illegal  <= user_mode & vaddr[31];
			miss     <= mapped & ~hit;
			invalid  <= mapped & hit & ~page_v;
			writable <= ~mapped | page_d;
			res_kind <= kind;
		end
	end

endmodule

`default_nettype wire

/* mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

	typedef enum logic [1:0] {
		ACC_FETCH = 2'd0,
		ACC_LOAD  = 2'd1,
		ACC_STORE = 2'd2
	} access_kind_e;

	// Codes stay internal to the MMU; the core maps them to its own cause field
	typedef enum logic [2:0] {
		EXC_NONE = 3'd0,
		EXC_ADEL = 3'd1,
		EXC_ADES = 3'd2,
		EXC_TLBL = 3'd3,
		EXC_TLBS = 3'd4,
		EXC_MOD  = 3'd5
	} exc_code_e;

	// TLBR, TLBWI and TLBP
	typedef enum logic [1:0] {
		CMD_READ  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_PROBE = 2'd2
	} tlb_cmd_e;

	// MS_ACK holds ack high until the requester drops req
	typedef enum logic [1:0] {
		MS_IDLE = 2'd0,
		MS_ACK  = 2'd1
	} maint_state_e;

endpackage

`default_nettype wire

/* tb_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module tb_mmu import mmu_pkg::*; ();

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 3;
	localparam int NUM_ROWS        = 22;
	localparam int MAINT_OPS       = 10;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * 4 + MAINT_OPS * 8 + 200;

	typedef struct {
		logic [7:0]   asid;
		logic         um;
		int           lane;
		logic [31:0]  vaddr;
		access_kind_e kind;
		logic [31:0]  paddr;
		logic         unc;
		exc_code_e    exc;
	} row_t;

	logic                           clk;
	logic                           arst_n;
	logic [`ASID_W-1:0]             asid;
	logic                           user_mode;
	logic [`VPN2_W-1:0]             probe_vpn2;
	logic                           maint_req;
	tlb_cmd_e                       maint_cmd;
	logic [`TLB_INDEX_W-1:0]        maint_index;
	logic [`TLB_ENTRY_W-1:0]        maint_wdata;
	logic                           maint_ack;
	logic [`TLB_ENTRY_W-1:0]        maint_rdata;
	logic                           probe_hit;
	logic [`TLB_INDEX_W-1:0]        probe_index;
	logic [`MMU_LANES-1:0]          lane_valid;
	logic [32*`MMU_LANES-1:0]       vaddr;
	access_kind_e [`MMU_LANES-1:0]  kind;
	logic [`MMU_LANES-1:0]          res_valid;
	logic [32*`MMU_LANES-1:0]       paddr;
	logic [`MMU_LANES-1:0]          uncached;
	exc_code_e [`MMU_LANES-1:0]     exc_code;
	logic                           any_fault;
	logic [1:0]                     fault_lane;

	row_t                           tbl [NUM_ROWS];
	logic [`ASID_W-1:0]             nxt_asid;
	logic                           nxt_um;
	logic [`MMU_LANES-1:0]          nxt_valid;
	logic [32*`MMU_LANES-1:0]       nxt_vaddr;
	access_kind_e [`MMU_LANES-1:0]  nxt_kind;
	// Row per lane for the next, the in-flight and the checked access; -1 is idle
	int                             set_row  [`MMU_LANES];
	int                             pend_row [`MMU_LANES];
	int                             chk_row  [`MMU_LANES];
	logic [11:0]                    set_off  [`MMU_LANES];
	logic [11:0]                    pend_off [`MMU_LANES];
	logic [11:0]                    chk_off  [`MMU_LANES];

	mmu i_mmu (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$fatal(1, "Watchdog expired");
	end

	task automatic check(input string name, input logic [71:0] got, input logic [71:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	function automatic logic [`TLB_ENTRY_W-1:0] make_entry(
		input logic [18:0] vpn2, input logic [7:0] asid_v, input logic g,
		input logic [19:0] pfn0, input logic v0, input logic d0,
		input logic [19:0] pfn1, input logic v1, input logic d1);
		return {vpn2, asid_v, g, pfn0, v0, d0, pfn1, v1, d1};
	endfunction

	// Runs the four-phase handshake and samples on the falling edge where outputs are stable
	task automatic maint(input tlb_cmd_e cmd, input logic [2:0] idx, input logic [71:0] wdata,
	                     input logic [18:0] vpn2, output logic [71:0] rdata,
	                     output logic hit, output logic [2:0] hit_idx);
		@(posedge clk);
		maint_req   <= 1'b1;
		maint_cmd   <= cmd;
		maint_index <= idx;
		maint_wdata <= wdata;
		probe_vpn2  <= vpn2;
		do begin
			@(negedge clk);
		end while (!maint_ack);
		rdata   = maint_rdata;
		hit     = probe_hit;
		hit_idx = probe_index;
		@(posedge clk);
		maint_req <= 1'b0;
		do begin
			@(negedge clk);
		end while (maint_ack);
	endtask

	task automatic write_entry(input logic [2:0] idx, input logic [71:0] e);
		logic [71:0] rd;
		logic        hit;
		logic [2:0]  hidx;

		maint(CMD_WRITE, idx, e, '0, rd, hit, hidx);
	endtask

	task automatic read_check(input logic [2:0] idx, input logic [71:0] exp);
		logic [71:0] rd;
		logic        hit;
		logic [2:0]  hidx;

		maint(CMD_READ, idx, '0, '0, rd, hit, hidx);
		check($sformatf("maint_rdata[%0d]", idx), rd, exp);
	endtask

	task automatic probe_check(input logic [18:0] vpn2, input logic exp_hit,
	                           input logic [2:0] exp_idx);
		logic [71:0] rd;
		logic        hit;
		logic [2:0]  hidx;

		maint(CMD_PROBE, '0, '0, vpn2, rd, hit, hidx);
		check("probe_hit", hit, exp_hit);
		if (exp_hit)
			check("probe_index", hidx, exp_idx);
	endtask

	task automatic set_lane(input int l, input int r);
		set_row[l]            = r;
		set_off[l]            = 12'($urandom);
		nxt_valid[l]          = 1'b1;
		nxt_vaddr[32*l +: 32] = tbl[r].vaddr | {20'd0, set_off[l]};
		nxt_kind[l]           = tbl[r].kind;
		nxt_asid              = tbl[r].asid;
		nxt_um                = tbl[r].um;
	endtask

	// Drives the prepared lanes and moves the tracking one pipeline stage on
	task automatic issue();
		@(posedge clk);
		asid       <= nxt_asid;
		user_mode  <= nxt_um;
		lane_valid <= nxt_valid;
		vaddr      <= nxt_vaddr;
		kind       <= nxt_kind;
		chk_row    = pend_row;
		chk_off    = pend_off;
		pend_row   = set_row;
		pend_off   = set_off;
		nxt_valid  = '0;
		set_row    = '{default: -1};
	endtask

	task automatic check_lanes();
		logic       exp_any;
		logic [1:0] exp_lane;
		int         r;

		exp_any  = 1'b0;
		exp_lane = 2'd0;
		@(negedge clk);
		for (int l = `MMU_LANES - 1; l >= 0; l--) begin
			r = chk_row[l];
			check($sformatf("res_valid[%0d]", l), res_valid[l], r >= 0);
			if (r < 0) begin
				check($sformatf("exc_code[%0d]", l), exc_code[l], EXC_NONE);
			end else begin
				check($sformatf("exc_code[%0d]", l), exc_code[l], tbl[r].exc);
				check($sformatf("uncached[%0d]", l), uncached[l], tbl[r].unc);
				if (tbl[r].exc == EXC_NONE) begin
					check($sformatf("paddr[%0d]", l), paddr[32*l +: 32],
					      tbl[r].paddr | {20'd0, chk_off[l]});
				end else begin
					exp_any  = 1'b1;
					exp_lane = 2'(l);
				end
			end
		end
		check("any_fault", any_fault, exp_any);
		check("fault_lane", fault_lane, exp_lane);
	endtask

	initial begin
		logic [71:0] e0;
		logic [71:0] e1;
		logic [71:0] e2;
		logic [71:0] e5;
		int          lane;

		void'($urandom(51));
		clk         = 1'b0;
		arst_n      = 1'b0;
		asid        = '0;
		user_mode   = 1'b0;
		probe_vpn2  = '0;
		maint_req   = 1'b0;
		maint_cmd   = CMD_READ;
		maint_index = '0;
		maint_wdata = '0;
		lane_valid  = '0;
		vaddr       = '0;
		nxt_asid    = '0;
		nxt_um      = 1'b0;
		nxt_valid   = '0;
		nxt_vaddr   = '0;
		for (int l = 0; l < `MMU_LANES; l++) begin
			kind[l]     = ACC_LOAD;
			nxt_kind[l] = ACC_LOAD;
			set_off[l]  = '0;
			pend_off[l] = '0;
		end
		set_row  = '{default: -1};
		pend_row = '{default: -1};

		// asid, user mode, lane (3 picks a random lane), vaddr, kind, paddr, uncached, code
		tbl = '{
			'{8'h05, 1'b0, 0, 32'h8000_1000, ACC_FETCH, 32'h0000_1000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 1, 32'h9FC0_0000, ACC_LOAD,  32'h1FC0_0000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 2, 32'hA000_2000, ACC_STORE, 32'h0000_2000, 1'b1, EXC_NONE},
			'{8'h05, 1'b0, 3, 32'hBFC0_0000, ACC_LOAD,  32'h1FC0_0000, 1'b1, EXC_NONE},
			'{8'h05, 1'b0, 3, 32'h8123_4000, ACC_STORE, 32'h0123_4000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 1, 32'h0040_0000, ACC_LOAD,  32'h1234_5000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 2, 32'h0040_1000, ACC_LOAD,  32'h2345_6000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 3, 32'h0040_0000, ACC_STORE, 32'h1234_5000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 2, 32'h0040_1000, ACC_STORE, 32'h0,         1'b0, EXC_MOD},
			'{8'h05, 1'b0, 0, 32'h0040_1000, ACC_FETCH, 32'h2345_6000, 1'b0, EXC_NONE},
			'{8'h05, 1'b0, 3, 32'hC000_0000, ACC_LOAD,  32'h0ABC_D000, 1'b0, EXC_NONE},
			'{8'h77, 1'b0, 3, 32'hC000_0000, ACC_STORE, 32'h0ABC_D000, 1'b0, EXC_NONE},
			'{8'h07, 1'b1, 3, 32'h0060_0000, ACC_LOAD,  32'h0077_7000, 1'b0, EXC_NONE},
			'{8'h06, 1'b0, 1, 32'h0040_0000, ACC_LOAD,  32'h0,         1'b0, EXC_TLBL},
			'{8'h06, 1'b0, 2, 32'h0040_0000, ACC_STORE, 32'h0,         1'b0, EXC_TLBS},
			'{8'h05, 1'b0, 3, 32'h0080_0000, ACC_LOAD,  32'h0,         1'b0, EXC_TLBL},
			'{8'h05, 1'b0, 3, 32'hC000_1000, ACC_LOAD,  32'h0,         1'b0, EXC_TLBL},
			'{8'h05, 1'b0, 3, 32'hC000_1000, ACC_STORE, 32'h0,         1'b0, EXC_TLBS},
			'{8'h05, 1'b1, 3, 32'h8000_0000, ACC_LOAD,  32'h0,         1'b0, EXC_ADEL},
			'{8'h05, 1'b1, 3, 32'hC080_0000, ACC_STORE, 32'h0,         1'b0, EXC_ADES},
			'{8'h05, 1'b1, 0, 32'hA000_0000, ACC_FETCH, 32'h0,         1'b1, EXC_ADEL},
			'{8'h05, 1'b0, 3, 32'hE000_0000, ACC_LOAD,  32'h0,         1'b0, EXC_TLBL}
		};
		e0 = make_entry(19'h00200, 8'h05, 1'b0, 20'h12345, 1'b1, 1'b1, 20'h23456, 1'b1, 1'b0);
		e1 = make_entry(19'h60000, 8'h00, 1'b1, 20'h0ABCD, 1'b1, 1'b1, 20'h0BCDE, 1'b0, 1'b0);
		e2 = make_entry(19'h00300, 8'h07, 1'b0, 20'h00777, 1'b1, 1'b1, 20'h00888, 1'b1, 1'b1);
		e5 = make_entry(19'h00200, 8'h05, 1'b0, 20'h55555, 1'b1, 1'b1, 20'h66666, 1'b1, 1'b1);

		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check("maint_ack", maint_ack, 1'b0);
		check("res_valid", res_valid, '0);
		check("any_fault", any_fault, 1'b0);
		@(posedge clk);
		arst_n <= 1'b1;

		read_check(3'd3, '0);
		write_entry(3'd0, e0);
		write_entry(3'd1, e1);
		write_entry(3'd2, e2);
		write_entry(3'd5, e5);
		read_check(3'd0, e0);
		read_check(3'd5, e5);
		nxt_asid = 8'h05;
		issue();
		probe_check(19'h00200, 1'b1, 3'd0);
		probe_check(19'h60000, 1'b1, 3'd1);
		probe_check(19'h12345, 1'b0, 3'd0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			lane = (tbl[r].lane >= `MMU_LANES) ? int'($urandom % `MMU_LANES) : tbl[r].lane;
			set_lane(lane, r);
			issue();
			issue();
			check_lanes();
		end

		// The same row on every lane at once with a separate page offset per lane
		for (int l = 0; l < `MMU_LANES; l++)
			set_lane(l, 6);
		issue();
		issue();
		check_lanes();
		set_lane(0, 5);
		set_lane(1, 15);
		set_lane(2, 8);
		issue();
		issue();
		check_lanes();
		set_lane(0, 9);
		set_lane(1, 7);
		set_lane(2, 8);
		issue();
		issue();
		check_lanes();

		// Back-to-back accesses on one lane
		set_lane(1, 5);
		issue();
		set_lane(1, 13);
		issue();
		check_lanes();
		set_lane(1, 16);
		issue();
		check_lanes();
		issue();
		check_lanes();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tlb_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module tlb_array import mmu_pkg::*; (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic [`ASID_W-1:0]                      asid,
	input  logic                                    maint_req,
	input  tlb_cmd_e                                maint_cmd,
	input  logic [`TLB_INDEX_W-1:0]                 maint_index,
	input  logic [`TLB_ENTRY_W-1:0]                 maint_wdata,
	output logic                                    maint_ack,
	output logic [`TLB_ENTRY_W-1:0]                 maint_rdata,
	output logic                                    probe_hit,
	output logic [`TLB_INDEX_W-1:0]                 probe_index,
	input  logic [`VPN2_W-1:0]                      probe_vpn2,
	output logic [`TLB_ENTRIES*`TLB_ENTRY_W-1:0]    entries
);

	logic [`TLB_ENTRIES-1:0][`TLB_ENTRY_W-1:0] entry_q;
	maint_state_e                              state_q;
	logic                                      cmd_fire;
	logic                                      probe_found;
	logic [`TLB_INDEX_W-1:0]                   probe_sel;

	// A command executes once, on the edge that moves IDLE to ACK
	assign cmd_fire  = (state_q == MS_IDLE) && maint_req;
	assign maint_ack = (state_q == MS_ACK);
	assign entries   = entry_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= MS_IDLE;
		end else begin
			case (state_q)
				MS_IDLE: begin
					if (maint_req) begin
						state_q <= MS_ACK;
					end
				end
				MS_ACK: begin
					if (!maint_req) begin
						state_q <= MS_IDLE;
					end
				end
				default: begin
					state_q <= MS_IDLE;
				end
			endcase
		end
	end

	// Cleared entries are invalid and non-global
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			entry_q <= '0;
		end else if (cmd_fire && maint_cmd == CMD_WRITE) begin
			entry_q[maint_index] <= maint_wdata;
		end
	end

	// Scan from the top so the lowest matching index wins
	always_comb begin
		logic [`TLB_ENTRY_W-1:0] cur;

		probe_found = 1'b0;
		probe_sel   = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			cur = entry_q[i];
			if (cur[`TLB_VPN2_LSB +: `VPN2_W] == probe_vpn2 &&
			    (cur[`TLB_ASID_LSB +: `ASID_W] == asid || cur[`TLB_G_BIT])) begin
				probe_found = 1'b1;
				probe_sel   = `TLB_INDEX_W'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			probe_hit <= 1'b0;
		end else if (cmd_fire && maint_cmd == CMD_PROBE) begin
			probe_hit <= probe_found;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire && maint_cmd == CMD_READ) begin
			maint_rdata <= entry_q[maint_index];
		end
		if (cmd_fire && maint_cmd == CMD_PROBE) begin
			probe_index <= probe_sel;
		end
	end

endmodule

`default_nettype wire
